/* flist.f */
logic/videoPkg.sv
logic/gpuPkg.sv
logic/gpuRegs.sv
logic/spanWriter.sv
logic/frameBuffer.sv
logic/videoTiming.sv
logic/scanOut.sv
logic/gpuTop.sv
tb/gpuTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module gpuTb -o gpuSim
./obj_dir/gpuSim > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi

/* tb/gpuTb.sv */
`default_nettype none

module gpuTb
    import gpuPkg::*;
    import videoPkg::*;
();

    localparam int W       = 32;
    localparam int H       = 16;
    localparam int TIMEOUT = 2000;  // two frames and some margin

    logic        clk;
    logic        rstn;
    logic [7:0]  addrIn;
    logic [7:0]  addrOut;
    logic [3:0]  sizeDecode;
    logic [31:0] dataIn;
    logic [31:0] dataOut;
    videoOut_t   videoOut;

    pixel_t     model [2][H][W];  // expected image per bank
    bit         drawn [2][H][W];
    pixel_t     shown [H][W];     // last frame seen on videoOut
    pixel_t     lastFrame [H][W];
    logic [3:0] masks [11] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h5, 4'hA, 4'h3, 4'hC, 4'h6, 4'h9, 4'hE};
    int         seed = 32'hae5e;
    int         errors = 0;
    int         testErrors = 0;
    int         passed = 0;
    int         failed = 0;
    int         monCol = 0;
    int         monRow = 0;
    int         vsRises = 0;
    int         sinceDeFall = 0;
    int         sinceHs = -1;     // no hsync seen yet
    int         hsWidth = 0;
    logic       prevDe = 1'b0;
    logic       prevVs = 1'b0;
    logic       prevHs = 1'b0;
    logic       drawBank = 1'b0;
    string      testName = "";

    gpuTop u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("** Error %s: expected %h, actual %h", name, exp, act);
        errors++;
    endtask

    task automatic checkWord(input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
            report(testName, exp, act);
    endtask

    task automatic abortRun(input string why);
        $display("%s: %s", testName, why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = errors;
    endtask

    task automatic finishTest();
        $display("%-14s %s", testName, (errors == testErrors) ? "ok" : "FAILED");
        if (errors == testErrors)
            passed++;
        else
            failed++;
    endtask

    function automatic pixel_t randomPixel();
        logic [31:0] r;
        r = $random(seed);
        return r[23:0];
    endfunction

    task automatic writeReg(input logic [3:0] addr, input logic [31:0] data, input logic [3:0] size);
        @(posedge clk);
        #2;
        addrIn     = {4'h0, addr};
        dataIn     = data;
        sizeDecode = size;
        @(posedge clk);
        #2;
        sizeDecode = 4'h0;
    endtask

    task automatic readReg(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        #2;
        addrOut = {4'h0, addr};
        @(negedge clk);
        @(negedge clk);  // dataOut is registered
        data = dataOut;
    endtask

    task automatic waitSpanDone(output logic sawBusy);
        logic [31:0] data;
        int          polls;
        polls = 0;
        readReg(REG_BUSY, data);
        sawBusy = data[0];
        // addrOut stays on word 7, a short span is busy for one cycle only
        while (!sawBusy && polls < TIMEOUT)
        begin
            @(negedge clk);
            sawBusy = dataOut[0];
            polls++;
        end
        data  = 32'h1;
        polls = 0;
        while (data != 32'h0)
        begin
            polls++;
            if (polls > TIMEOUT)
                abortRun("enable word never cleared");
            readReg(REG_ENABLE, data);
        end
    endtask

    task automatic drawSpan(input int x, input int y, input int len, input pixel_t color);
        logic sawBusy;
        writeReg(REG_X, x, 4'hF);
        writeReg(REG_Y, y, 4'hF);
        writeReg(REG_COLOR, {8'h5a, color}, 4'hF);  // pad byte is ignored
        writeReg(REG_LEN, len, 4'hF);
        writeReg(REG_ENABLE, 32'h1, 4'hF);
        waitSpanDone(sawBusy);
        checkWord(32'h1, 32'(sawBusy));
        // a run stops at the row end and never wraps
        for (int i = x; i < x + len && i < W && y < H; i++)
        begin
            model[drawBank][y][i] = color;
            drawn[drawBank][y][i] = 1'b1;
        end
    endtask

    task automatic drawRandomSpans(input int count);
        logic [31:0] span;
        for (int s = 0; s < count; s++)
        begin
            span = $random(seed);
            drawSpan(span[7:0] % W, span[15:8] % H, span[19:16] + 4, randomPixel());
        end
    endtask

    task automatic swapBanks();
        drawBank = !drawBank;
        writeReg(REG_BANK, {31'b0, drawBank}, 4'hF);
    endtask

    task automatic waitFrame();
        int start;
        int cycles;
        start  = vsRises;
        cycles = 0;
        while (vsRises < start + 2)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                abortRun("no complete frame on the video output");
        end
    endtask

    // monitor state only changes on negedge, so it is stable here
    task automatic waitVideo(input bit wantVsync);
        int cycles;
        cycles = 0;
        while (wantVsync ? !prevVs : !(prevDe && monCol == W / 2))
        begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                abortRun(wantVsync ? "vsync never seen" : "active line never seen");
        end
    endtask

    task automatic checkShown();
        for (int r = 0; r < H; r++)
            for (int c = 0; c < W; c++)
                if (drawn[!drawBank][r][c])
                    checkWord(32'(model[!drawBank][r][c]), 32'(shown[r][c]));
    endtask

    // rebuild column and row from de and sync edges
    always @(negedge clk)
    begin
        if (sinceHs >= 0)
            sinceHs++;
        sinceDeFall++;
        if (!videoOut.de && prevDe)
            sinceDeFall = 0;
        if (videoOut.hsync)
            hsWidth++;
        if (videoOut.hsync && !prevHs)
        begin
            if (sinceHs >= 0)
            begin
                assert (sinceHs == W + H_FRONT + H_SYNC + H_BACK)
                else
                    report({testName, " hsync period"}, W + H_FRONT + H_SYNC + H_BACK, sinceHs);
            end
            if (sinceDeFall < W)  // front porch of an active line
            begin
                assert (sinceDeFall == H_FRONT)
                else
                    report({testName, " hsync start"}, H_FRONT, sinceDeFall);
            end
            sinceHs = 0;
        end
        if (!videoOut.hsync && prevHs)
        begin
            assert (hsWidth == H_SYNC)
            else
                report({testName, " hsync width"}, H_SYNC, hsWidth);
            hsWidth = 0;
        end
        if (videoOut.vsync && !prevVs)
        begin
            assert (monRow == H)
            else
                report({testName, " lines/frame"}, H, monRow);
            monRow = 0;
            vsRises++;
        end
        if (videoOut.de)
        begin
            if (monRow < H && monCol < W)
                shown[monRow][monCol] = videoOut.rgb;
            monCol++;
        end
        else if (prevDe)
        begin
            assert (monCol == W)
            else
                report({testName, " pixels/line"}, W, monCol);
            monCol = 0;
            monRow++;
        end
        prevDe = videoOut.de;
        prevVs = videoOut.vsync;
        prevHs = videoOut.hsync;
    end

    assert property (@(posedge clk) disable iff (!rstn) !videoOut.de |-> videoOut.rgb == '0)
    else
        report({testName, " blanking"}, 32'h0, 32'($sampled(videoOut.rgb)));

    initial
    begin
        logic [31:0] data;
        logic [31:0] oldWord;
        logic [31:0] newWord;
        logic [31:0] merged;
        logic [3:0]  addr;
        rstn       = 1'b0;
        addrIn     = '0;
        addrOut    = '0;
        sizeDecode = '0;
        dataIn     = '0;
        repeat (2) @(posedge clk);
        #2;
        rstn = 1'b1;

        startTest("reset");
        for (int a = 0; a < 16; a++)
        begin
            readReg(4'(a), data);
            checkWord(32'h0, data);
        end
        finishTest();

        startTest("byteWrites");
        for (int k = 0; k < 11; k++)
        begin
            addr    = (k < 4) ? 4'(k) : 4'(k + 5);  // words 0-3 and 9-15
            oldWord = {4{8'(8'h30 + k)}};
            newWord = $random(seed);
            writeReg(addr, oldWord, 4'hF);
            writeReg(addr, newWord, masks[k]);
            for (int b = 0; b < 4; b++)
                merged[8*b +: 8] = masks[k][b] ? newWord[8*b +: 8] : oldWord[8*b +: 8];
            readReg(addr, data);
            checkWord(merged, data);
        end
        for (int a = 5; a < 8; a++)
        begin
            writeReg(4'(a), 32'hFFFF_FFFF, 4'hF);
            readReg(4'(a), data);
            checkWord(32'h0, data & ~32'(a == 6));  // vblank bit may be live
        end
        finishTest();

        startTest("enableClear");
        drawSpan(4, 2, 8, randomPixel());
        drawSpan(4, 2, 0, randomPixel());  // must leave the pixels alone
        readReg(REG_ENABLE, data);
        checkWord(32'h0, data);
        finishTest();

        startTest("drawnPixels");
        drawRandomSpans(6);
        swapBanks();
        waitFrame();
        checkShown();
        finishTest();

        startTest("clipping");
        drawSpan(0, 5, W, randomPixel());
        drawSpan(0, 6, W, randomPixel());
        drawSpan(W - 3, 5, 10, randomPixel());
        swapBanks();
        waitFrame();
        checkShown();
        finishTest();

        startTest("bankIsolation");
        lastFrame = shown;
        drawRandomSpans(4);
        waitFrame();
        for (int r = 0; r < H; r++)
            for (int c = 0; c < W; c++)
                checkWord(32'(lastFrame[r][c]), 32'(shown[r][c]));
        finishTest();

        startTest("vblank");
        waitVideo(1'b1);
        readReg(REG_VBLANK, data);
        checkWord(32'h1, data);
        waitVideo(1'b0);
        readReg(REG_VBLANK, data);
        checkWord(32'h0, data);
        finishTest();

        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/gpuTop.sv */
`default_nettype none

module gpuTop
    import gpuPkg::*;
    import videoPkg::*;
#(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 16
)
(
    input  logic        clk,
    input  logic        rstn,
    input  logic [7:0]  addrIn,
    input  logic [7:0]  addrOut,
    input  logic [3:0]  sizeDecode,
    input  logic [31:0] dataIn,
    output logic [31:0] dataOut,
    output videoOut_t   videoOut
);

    localparam int XW = $clog2(FB_WIDTH);
    localparam int YW = $clog2(FB_HEIGHT);
    localparam int AW = 1 + YW + XW;

    spanCmd_t      spanCmd;
    logic          spanEnable;
    logic          drawBank;
    logic          busy;
    logic          vBlank;
    logic          fbWrite;
    logic [AW-1:0] fbWriteAddr;
    pixel_t        fbWriteData;
    logic [AW-1:0] fbReadAddr;
    pixel_t        fbReadData;
    logic [XW-1:0] column;
    logic [YW-1:0] row;
    logic          hsync;
    logic          vsync;
    logic          activeVideo;

    gpuRegs u_regs (
        .clk        (clk),
        .rstn       (rstn),
        .addrIn     (addrIn),
        .addrOut    (addrOut),
        .sizeDecode (sizeDecode),
        .dataIn     (dataIn),
        .vBlank     (vBlank),
        .busy       (busy),
        .dataOut    (dataOut),
        .spanCmd    (spanCmd),
        .spanEnable (spanEnable),
        .drawBank   (drawBank)
    );

    spanWriter #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_spanWriter (
        .clk         (clk),
        .rstn        (rstn),
        .spanCmd     (spanCmd),
        .spanEnable  (spanEnable),
        .drawBank    (drawBank),
        .busy        (busy),
        .fbWrite     (fbWrite),
        .fbWriteAddr (fbWriteAddr),
        .fbWriteData (fbWriteData)
    );

    frameBuffer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_frameBuffer (
        .clk         (clk),
        .fbWrite     (fbWrite),
        .fbWriteAddr (fbWriteAddr),
        .fbWriteData (fbWriteData),
        .fbReadAddr  (fbReadAddr),
        .fbReadData  (fbReadData)
    );

    videoTiming #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_videoTiming (
        .clk         (clk),
        .rstn        (rstn),
        .column      (column),
        .row         (row),
        .hsync       (hsync),
        .vsync       (vsync),
        .activeVideo (activeVideo),
        .vBlank      (vBlank)
    );

    scanOut #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_scanOut (
        .clk         (clk),
        .rstn        (rstn),
        .column      (column),
        .row         (row),
        .hsync       (hsync),
        .vsync       (vsync),
        .activeVideo (activeVideo),
        .drawBank    (drawBank),
        .fbReadData  (fbReadData),
        .fbReadAddr  (fbReadAddr),
        .videoOut    (videoOut)
    );

endmodule

`default_nettype wire

/* logic/scanOut.sv */
`default_nettype none

module scanOut
    import videoPkg::*;
#(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 16
)
(
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [$clog2(FB_WIDTH)-1:0]   column,
    input  logic [$clog2(FB_HEIGHT)-1:0]  row,
    input  logic                          hsync,
    input  logic                          vsync,
    input  logic                          activeVideo,
    input  logic                          drawBank,
    input  pixel_t                        fbReadData,
    output logic [AW-1:0]                 fbReadAddr,
    output videoOut_t                     videoOut
);

    localparam int AW = 1 + $clog2(FB_HEIGHT) + $clog2(FB_WIDTH);

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } syncBits_t;

    syncBits_t syncD1;  // with the address
    syncBits_t syncD2;  // with the read data

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            syncD1 <= '0;
            syncD2 <= '0;
        end
        else
        begin
            syncD1 <= '{hsync: hsync, vsync: vsync, de: activeVideo};
            syncD2 <= syncD1;
        end
    end

    // display the bank that is not being drawn
    always_ff @(posedge clk)
    begin
        fbReadAddr <= {~drawBank, row, column};
    end

    assign videoOut.hsync = syncD2.hsync;
    assign videoOut.vsync = syncD2.vsync;
    assign videoOut.de    = syncD2.de;
    assign videoOut.rgb   = syncD2.de ? fbReadData : '0;  // black in blanking

endmodule

`default_nettype wire

/* logic/videoTiming.sv */
`default_nettype none

module videoTiming
    import videoPkg::*;
#(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 16
)
(
    input  logic                          clk,
    input  logic                          rstn,
    output logic [$clog2(FB_WIDTH)-1:0]   column,
    output logic [$clog2(FB_HEIGHT)-1:0]  row,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          activeVideo,
    output logic                          vBlank
);

    localparam int H_TOTAL  = FB_WIDTH + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = FB_HEIGHT + V_FRONT + V_SYNC + V_BACK;
    localparam int HW       = $clog2(H_TOTAL);
    localparam int VW       = $clog2(V_TOTAL);
    localparam int HS_START = FB_WIDTH + H_FRONT;
    localparam int VS_START = FB_HEIGHT + V_FRONT;

    logic [HW-1:0] hCnt;
    logic [VW-1:0] vCnt;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            hCnt <= '0;
            vCnt <= '0;
        end
        else if (32'(hCnt) == H_TOTAL - 1)
        begin
            hCnt <= '0;
            if (32'(vCnt) == V_TOTAL - 1)
                vCnt <= '0;
            else
                vCnt <= vCnt + 1'b1;
        end
        else
            hCnt <= hCnt + 1'b1;
    end

    assign column = hCnt[$clog2(FB_WIDTH)-1:0];
    assign row    = vCnt[$clog2(FB_HEIGHT)-1:0];

    assign hsync       = (32'(hCnt) >= HS_START) && (32'(hCnt) < HS_START + H_SYNC);
    assign vsync       = (32'(vCnt) >= VS_START) && (32'(vCnt) < VS_START + V_SYNC);
    assign vBlank      = 32'(vCnt) >= FB_HEIGHT;  // whole line, not just sync
    assign activeVideo = (32'(hCnt) < FB_WIDTH) && !vBlank;

endmodule

`default_nettype wire

/* logic/frameBuffer.sv */
`default_nettype none

module frameBuffer
    import videoPkg::*;
#(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 16
)
(
    input  logic          clk,
    input  logic          fbWrite,
    input  logic [AW-1:0] fbWriteAddr,
    input  pixel_t        fbWriteData,
    input  logic [AW-1:0] fbReadAddr,
    output pixel_t        fbReadData
);

    localparam int AW    = 1 + $clog2(FB_WIDTH) + $clog2(FB_HEIGHT);
    localparam int DEPTH = 2 * FB_WIDTH * FB_HEIGHT;

    // bank is the top address bit
    pixel_t mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (fbWrite)
            mem[fbWriteAddr] <= fbWriteData;
    end

    // read data one clock after the address
    always_ff @(posedge clk)
    begin
        fbReadData <= mem[fbReadAddr];
    end

endmodule

`default_nettype wire

/* logic/spanWriter.sv */
`default_nettype none

module spanWriter
    import gpuPkg::*;
    import videoPkg::*;
#(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 16
)
(
    input  logic                clk,
    input  logic                rstn,
    input  spanCmd_t            spanCmd,
    input  logic                spanEnable,
    input  logic                drawBank,
    output logic                busy,
    output logic                fbWrite,
    output logic [AW-1:0]       fbWriteAddr,
    output pixel_t              fbWriteData
);

    localparam int XW = $clog2(FB_WIDTH);
    localparam int YW = $clog2(FB_HEIGHT);
    localparam int AW = 1 + YW + XW;

    logic          start;
    logic          inRange;
    logic [23:0]   room;
    logic [XW:0]   count;
    logic          doWrite;
    logic [XW:0]   remain;    // write cycles left, current one included
    logic          bank;
    logic [YW-1:0] row;
    logic [XW-1:0] col;
    pixel_t        color;

    assign start   = spanEnable && !busy;
    assign inRange = (32'(spanCmd.x) < FB_WIDTH) && (32'(spanCmd.y) < FB_HEIGHT)
                     && (spanCmd.len != '0);
    assign room    = 24'(FB_WIDTH) - 24'(spanCmd.x);
    assign count   = (spanCmd.len < room) ? spanCmd.len[XW:0] : room[XW:0];  // clip at row end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            busy    <= 1'b0;
            doWrite <= 1'b0;
            remain  <= '0;
        end
        else if (start)
        begin
            busy    <= 1'b1;
            doWrite <= inRange;
            remain  <= count;
        end
        else if (busy)
        begin
            remain <= remain - 1'b1;
            if (!doWrite || remain == 1)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            bank  <= drawBank;
            row   <= spanCmd.y[YW-1:0];
            col   <= spanCmd.x[XW-1:0];
            color <= spanCmd.color;
        end
        else if (busy)
            col <= col + 1'b1;
    end

    assign fbWrite     = busy && doWrite;
    assign fbWriteAddr = {bank, row, col};
    assign fbWriteData = color;

endmodule

`default_nettype wire

/* logic/gpuRegs.sv */
`default_nettype none

module gpuRegs
    import gpuPkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic [7:0]  addrIn,
    input  logic [7:0]  addrOut,
    input  logic [3:0]  sizeDecode,
    input  logic [31:0] dataIn,
    input  logic        vBlank,
    input  logic        busy,
    output logic [31:0] dataOut,
    output spanCmd_t    spanCmd,
    output logic        spanEnable,
    output logic        drawBank
);

    regWord_t regs [REG_WORDS];
    logic     enableState;  // busy seen for current command
    logic     enableBit;
    logic     busySeen;

    assign enableBit = regs[REG_ENABLE].raw[0];
    assign busySeen  = regs[REG_BUSY].raw[0];

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < REG_WORDS; i++)
            begin
                regs[i] <= '0;
            end
            enableState <= 1'b0;
            dataOut     <= '0;
        end
        else
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (sizeDecode[b])
                    regs[addrIn[3:0]].raw[8*b +: 8] <= dataIn[8*b +: 8];
            end

            // status words win over host writes
            regs[REG_RSVD].raw   <= '0;
            regs[REG_VBLANK].raw <= {31'b0, vBlank};
            regs[REG_BUSY].raw   <= {31'b0, busy};

            dataOut <= regs[addrOut[3:0]].raw;

            if (busySeen && enableBit)
                enableState <= 1'b1;

            // busy went up and came back down, span is finished
            if (enableState && !busySeen && enableBit)
            begin
                enableState          <= 1'b0;
                regs[REG_ENABLE].raw <= '0;
            end
        end
    end

    // hold off a restart while the stored busy still lags the writer
    assign spanEnable = enableBit && !enableState && !busySeen;

    assign spanCmd.x     = regs[REG_X].raw[15:0];
    assign spanCmd.y     = regs[REG_Y].raw[15:0];
    assign spanCmd.color = regs[REG_COLOR].pix.color;
    assign spanCmd.len   = regs[REG_LEN].raw[23:0];

    assign drawBank = |regs[REG_BANK].raw;  // ping/pong

endmodule

`default_nettype wire

/* logic/gpuPkg.sv */
`default_nettype none

package gpuPkg;
    import videoPkg::*;

    localparam int REG_WORDS = 16;

    // word indices, 5 is reserved
    localparam logic [3:0] REG_X      = 4'd0;
    localparam logic [3:0] REG_Y      = 4'd1;
    localparam logic [3:0] REG_COLOR  = 4'd2;
    localparam logic [3:0] REG_LEN    = 4'd3;
    localparam logic [3:0] REG_ENABLE = 4'd4;
    localparam logic [3:0] REG_RSVD   = 4'd5;
    localparam logic [3:0] REG_VBLANK = 4'd6;
    localparam logic [3:0] REG_BUSY   = 4'd7;
    localparam logic [3:0] REG_BANK   = 4'd8;

    // colour word is written raw, read back as rgb
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [7:0] pad;
            pixel_t     color;
        } pix;
    } regWord_t;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        pixel_t      color;
        logic [23:0] len;
    } spanCmd_t;

endpackage

`default_nettype wire

/* logic/videoPkg.sv */
`default_nettype none

package videoPkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   de;
        pixel_t rgb;
    } videoOut_t;

    // blanking in clocks per line
    localparam int H_FRONT = 2;
    localparam int H_SYNC  = 4;
    localparam int H_BACK  = 2;

    // blanking in lines per frame
    localparam int V_FRONT = 1;
    localparam int V_SYNC  = 2;
    localparam int V_BACK  = 1;

endpackage

`default_nettype wire
